// ==== common/modemPkg.sv ====
`default_nettype none

package modemPkg;

	localparam int SAMPLE_WIDTH = 8;
	// Two guard bits for the CORDIC gain of about 1.65
	localparam int STAGE_WIDTH = 10;
	// A full turn is 1024 units
	localparam int ANGLE_WIDTH = 10;
	// Quarter turn per bit on a 16 phase table
	localparam int SYMBOL_SAMPLES = 4;

	typedef logic signed [SAMPLE_WIDTH-1:0] sampleT;
	typedef logic signed [STAGE_WIDTH-1:0]  stageT;
	typedef logic [ANGLE_WIDTH-1:0]         angleT;
	typedef logic [3:0]                     nibbleT;

	typedef enum logic [1:0] {
		PROBE_OFF      = 2'd0,
		PROBE_TX_LEVEL = 2'd1,
		PROBE_RX_LEVEL = 2'd2,
		PROBE_ANGLE    = 2'd3
	} probeSelT;

	typedef enum logic {
		TX_IDLE   = 1'b0,
		TX_SYMBOL = 1'b1
	} txStateT;

	// Arctangent of 2**-k in angle units
	function automatic angleT cordicAtan(input int k);
		angleT atan;
		case (k)
			0:       atan = ANGLE_WIDTH'(128);
			1:       atan = ANGLE_WIDTH'(76);
			2:       atan = ANGLE_WIDTH'(40);
			3:       atan = ANGLE_WIDTH'(20);
			4:       atan = ANGLE_WIDTH'(10);
			5:       atan = ANGLE_WIDTH'(5);
			6:       atan = ANGLE_WIDTH'(3);
			7, 8:    atan = ANGLE_WIDTH'(1);
			default: atan = '0;
		endcase
		return atan;
	endfunction

endpackage

`default_nettype wire

// ==== design/txFifo.sv ====
`default_nettype none
`timescale 1ns/10ps

module txFifo #(
	parameter int FIFO_DEPTH = 8
) (
	input  wire                   inClock,
	input  wire                   i_arstN,
	input  wire                   i_txWrite,
	input  wire modemPkg::nibbleT i_txData,
	input  wire                   i_bitTaken,
	output logic                  o_bit,
	output logic                  o_bitEmpty,
	output logic                  o_writeError,
	output logic [3:0]            o_level
);
	import modemPkg::*;

	localparam int PTR_WIDTH = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
	localparam int CNT_WIDTH = $clog2(FIFO_DEPTH + 1);

	nibbleT               store [FIFO_DEPTH];
	logic [PTR_WIDTH-1:0] wrPtr;
	logic [PTR_WIDTH-1:0] rdPtr;
	logic [CNT_WIDTH-1:0] storeCount;
	logic                 storeFull;
	logic                 doWrite;
	logic                 doLoad;
	nibbleT               shifter;
	logic [1:0]           bitCount;
	logic                 shiftFull;

	assign storeFull = (storeCount == CNT_WIDTH'(FIFO_DEPTH));
	assign doWrite   = i_txWrite && !storeFull;
	// Refill when the shifter is idle or hands out its last bit
	assign doLoad    = (storeCount != '0) && (!shiftFull || (i_bitTaken && bitCount == 2'd3));

	always_ff @(posedge inClock) begin
		if (doWrite) begin
			store[wrPtr] <= i_txData;
		end
	end

	always_ff @(posedge inClock or negedge i_arstN) begin
		if (!i_arstN) begin
			wrPtr        <= '0;
			rdPtr        <= '0;
			storeCount   <= '0;
			o_writeError <= 1'b0;
		end else begin
			o_writeError <= i_txWrite && storeFull;
			if (doWrite) begin
				wrPtr <= (wrPtr == PTR_WIDTH'(FIFO_DEPTH - 1)) ? '0 : wrPtr + 1'b1;
			end
			if (doLoad) begin
				rdPtr <= (rdPtr == PTR_WIDTH'(FIFO_DEPTH - 1)) ? '0 : rdPtr + 1'b1;
			end
			storeCount <= storeCount + CNT_WIDTH'(doWrite) - CNT_WIDTH'(doLoad);
		end
	end

	////////////////////////////////////////////////////////////
	// Bit serializer, MSB first
	////////////////////////////////////////////////////////////
	always_ff @(posedge inClock or negedge i_arstN) begin
		if (!i_arstN) begin
			shifter   <= '0;
			bitCount  <= '0;
			shiftFull <= 1'b0;
		end else if (doLoad) begin
			shifter   <= store[rdPtr];
			bitCount  <= '0;
			shiftFull <= 1'b1;
		end else if (i_bitTaken) begin
			shifter  <= {shifter[2:0], 1'b0};
			bitCount <= bitCount + 1'b1;
			if (bitCount == 2'd3) begin
				shiftFull <= 1'b0;
			end
		end
	end

	assign o_bit      = shifter[3];
	assign o_bitEmpty = !shiftFull;
	assign o_level    = 4'(storeCount) + 4'(shiftFull);

endmodule

`default_nettype wire

// ==== design/mskModulator.sv ====
`default_nettype none
`timescale 1ns/10ps

module mskModulator #(
	parameter int SAMPLE_DIV = 4
) (
	input  wire              inClock,
	input  wire              i_arstN,
	input  wire              i_bit,
	input  wire              i_bitEmpty,
	output logic             o_bitTaken,
	output logic             o_sampleValid,
	output modemPkg::sampleT o_sampleI,
	output modemPkg::sampleT o_sampleQ,
	output logic             o_symbolLast
);
	import modemPkg::*;

	localparam int DIV_WIDTH = (SAMPLE_DIV > 1) ? $clog2(SAMPLE_DIV) : 1;
	localparam int SYM_WIDTH = $clog2(SYMBOL_SAMPLES);

	// One turn of sine, amplitude 100
	localparam sampleT SINE [16] = '{0, 38, 71, 92, 100, 92, 71, 38,
		0, -38, -71, -92, -100, -92, -71, -38};

	txStateT              state;
	logic [DIV_WIDTH-1:0] divCount;
	logic [SYM_WIDTH-1:0] sampleCount;
	logic                 curBit;
	logic [3:0]           phase;
	logic [3:0]           nextPhase;
	logic [3:0]           cosIdx;
	logic                 sampleTick;
	logic                 symbolEnd;

	assign sampleTick = (state == TX_SYMBOL) && (divCount == DIV_WIDTH'(SAMPLE_DIV - 1));
	assign symbolEnd  = sampleTick && (sampleCount == SYM_WIDTH'(SYMBOL_SAMPLES - 1));
	assign o_bitTaken = !i_bitEmpty && ((state == TX_IDLE) || symbolEnd);
	// Plus a sixteenth turn for a one, minus for a zero
	assign nextPhase  = curBit ? phase + 4'd1 : phase - 4'd1;
	assign cosIdx     = nextPhase + 4'd4;

	always_ff @(posedge inClock or negedge i_arstN) begin
		if (!i_arstN) begin
			state         <= TX_IDLE;
			divCount      <= '0;
			sampleCount   <= '0;
			curBit        <= 1'b0;
			phase         <= '0;
			o_sampleValid <= 1'b0;
			o_symbolLast  <= 1'b0;
		end else begin
			o_sampleValid <= sampleTick;
			o_symbolLast  <= symbolEnd;
			if (o_bitTaken) begin
				curBit <= i_bit;
			end
			if (state == TX_IDLE) begin
				divCount    <= '0;
				sampleCount <= '0;
				if (o_bitTaken) begin
					state <= TX_SYMBOL;
				end
			end else if (sampleTick) begin
				divCount    <= '0;
				sampleCount <= symbolEnd ? '0 : sampleCount + 1'b1;
				phase       <= nextPhase;
				// No bit waiting at the boundary
				if (symbolEnd && !o_bitTaken) begin
					state <= TX_IDLE;
				end
			end else begin
				divCount <= divCount + 1'b1;
			end
		end
	end

	always_ff @(posedge inClock) begin
		if (sampleTick) begin
			o_sampleI <= SINE[cosIdx];
			o_sampleQ <= SINE[nextPhase];
		end
	end

endmodule

`default_nettype wire

// ==== cordic/cordicPrep.sv ====
`default_nettype none
`timescale 1ns/10ps

module cordicPrep (
	input  wire                   inClock,
	input  wire                   i_arstN,
	input  wire                   i_valid,
	input  wire                   i_last,
	input  wire modemPkg::sampleT i_sampleI,
	input  wire modemPkg::sampleT i_sampleQ,
	output logic                  o_valid,
	output logic                  o_last,
	output modemPkg::stageT       o_I,
	output modemPkg::stageT       o_Q,
	output modemPkg::angleT       o_angle
);
	import modemPkg::*;

	localparam angleT QUARTER_TURN = ANGLE_WIDTH'(1 << (ANGLE_WIDTH - 2));

	stageT extI;
	stageT extQ;

	assign extI = i_sampleI;
	assign extQ = i_sampleQ;

	always_ff @(posedge inClock or negedge i_arstN) begin
		if (!i_arstN) begin
			o_valid <= 1'b0;
			o_last  <= 1'b0;
		end else begin
			o_valid <= i_valid;
			o_last  <= i_last;
		end
	end

	always_ff @(posedge inClock) begin
		if (i_valid) begin
			if (!extI[STAGE_WIDTH-1]) begin
				o_I     <= extI;
				o_Q     <= extQ;
				o_angle <= '0;
			end else if (!extQ[STAGE_WIDTH-1]) begin
				// Second quadrant, turn clockwise by a quarter
				o_I     <= extQ;
				o_Q     <= -extI;
				o_angle <= QUARTER_TURN;
			end else begin
				// Third quadrant, turn counterclockwise
				o_I     <= -extQ;
				o_Q     <= extI;
				o_angle <= -QUARTER_TURN;
			end
		end
	end

endmodule

`default_nettype wire

// ==== cordic/cordicStage.sv ====
`default_nettype none
`timescale 1ns/10ps

module cordicStage #(
	parameter int STAGE = 0
) (
	input  wire                   inClock,
	input  wire                   i_arstN,
	input  wire                   i_valid,
	input  wire                   i_last,
	input  wire modemPkg::stageT  i_I,
	input  wire modemPkg::stageT  i_Q,
	input  wire modemPkg::angleT  i_angle,
	output logic                  o_valid,
	output logic                  o_last,
	output modemPkg::stageT       o_I,
	output modemPkg::stageT       o_Q,
	output modemPkg::angleT       o_angle
);
	import modemPkg::*;

	localparam angleT ATAN = cordicAtan(STAGE);

	stageT shiftI;
	stageT shiftQ;

	assign shiftI = i_I >>> STAGE;
	assign shiftQ = i_Q >>> STAGE;

	always_ff @(posedge inClock or negedge i_arstN) begin
		if (!i_arstN) begin
			o_valid <= 1'b0;
			o_last  <= 1'b0;
		end else begin
			o_valid <= i_valid;
			o_last  <= i_last;
		end
	end

	always_ff @(posedge inClock) begin
		if (i_valid) begin
			if (!i_Q[STAGE_WIDTH-1]) begin
				// Above the axis, rotate clockwise
				o_I     <= i_I + shiftQ;
				o_Q     <= i_Q - shiftI;
				o_angle <= i_angle + ATAN;
			end else begin
				o_I     <= i_I - shiftQ;
				o_Q     <= i_Q + shiftI;
				o_angle <= i_angle - ATAN;
			end
		end
	end

endmodule

`default_nettype wire

// ==== design/bitSlicer.sv ====
`default_nettype none
`timescale 1ns/10ps

module bitSlicer (
	input  wire                  inClock,
	input  wire                  i_arstN,
	input  wire                  i_valid,
	input  wire                  i_last,
	input  wire modemPkg::angleT i_angle,
	output logic                 o_bitStrobe,
	output logic                 o_bit,
	output modemPkg::angleT      o_angle
);
	import modemPkg::*;

	// Room for a full symbol of worst case steps plus sign
	localparam int ACC_WIDTH = ANGLE_WIDTH + $clog2(SYMBOL_SAMPLES) + 1;

	angleT                         prevAngle;
	logic signed [ANGLE_WIDTH-1:0] step;
	logic signed [ACC_WIDTH-1:0]   stepSum;
	logic signed [ACC_WIDTH-1:0]   accNext;
	logic                          sumPositive;

	// Wrapped difference taken as a signed step
	assign step        = signed'(i_angle - prevAngle);
	assign accNext     = stepSum + step;
	assign sumPositive = !accNext[ACC_WIDTH-1] && (accNext != '0);

	always_ff @(posedge inClock or negedge i_arstN) begin
		if (!i_arstN) begin
			prevAngle   <= '0;
			stepSum     <= '0;
			o_bitStrobe <= 1'b0;
			o_bit       <= 1'b0;
		end else begin
			o_bitStrobe <= i_valid && i_last;
			if (i_valid) begin
				prevAngle <= i_angle;
				if (i_last) begin
					// Net rotation over the symbol decides the bit
					o_bit   <= sumPositive;
					stepSum <= '0;
				end else begin
					stepSum <= accNext;
				end
			end
		end
	end

	assign o_angle = prevAngle;

endmodule

`default_nettype wire

// ==== design/rxFifo.sv ====
`default_nettype none
`timescale 1ns/10ps

module rxFifo #(
	parameter int FIFO_DEPTH = 8
) (
	input  wire              inClock,
	input  wire              i_arstN,
	input  wire              i_bitStrobe,
	input  wire              i_bit,
	input  wire              i_rxRead,
	output logic             o_rxValid,
	output modemPkg::nibbleT o_rxData,
	output logic             o_readError,
	output logic             o_overflow,
	output logic [3:0]       o_level
);
	import modemPkg::*;

	localparam int PTR_WIDTH = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
	localparam int CNT_WIDTH = $clog2(FIFO_DEPTH + 1);

	logic [2:0]           packReg;
	logic [1:0]           packCount;
	nibbleT               newNibble;
	logic                 nibbleDone;
	nibbleT               store [FIFO_DEPTH];
	logic [PTR_WIDTH-1:0] wrPtr;
	logic [PTR_WIDTH-1:0] rdPtr;
	logic [CNT_WIDTH-1:0] count;
	logic                 storeFull;
	logic                 storeEmpty;
	logic                 doWrite;
	logic                 doRead;

	////////////////////////////////////////////////////////////
	// Bit packer, MSB arrives first
	////////////////////////////////////////////////////////////
	assign newNibble  = {packReg, i_bit};
	assign nibbleDone = i_bitStrobe && (packCount == 2'd3);

	always_ff @(posedge inClock or negedge i_arstN) begin
		if (!i_arstN) begin
			packReg   <= '0;
			packCount <= '0;
		end else if (i_bitStrobe) begin
			packReg   <= {packReg[1:0], i_bit};
			packCount <= packCount + 1'b1;
		end
	end

	assign storeFull  = (count == CNT_WIDTH'(FIFO_DEPTH));
	assign storeEmpty = (count == '0);
	assign doWrite    = nibbleDone && !storeFull;
	assign doRead     = i_rxRead && !storeEmpty;

	always_ff @(posedge inClock) begin
		if (doWrite) begin
			store[wrPtr] <= newNibble;
		end
	end

	always_ff @(posedge inClock or negedge i_arstN) begin
		if (!i_arstN) begin
			wrPtr       <= '0;
			rdPtr       <= '0;
			count       <= '0;
			o_overflow  <= 1'b0;
			o_rxValid   <= 1'b0;
			o_readError <= 1'b0;
		end else begin
			o_overflow  <= nibbleDone && storeFull;
			o_rxValid   <= doRead;
			o_readError <= i_rxRead && storeEmpty;
			if (doWrite) begin
				wrPtr <= (wrPtr == PTR_WIDTH'(FIFO_DEPTH - 1)) ? '0 : wrPtr + 1'b1;
			end
			if (doRead) begin
				rdPtr <= (rdPtr == PTR_WIDTH'(FIFO_DEPTH - 1)) ? '0 : rdPtr + 1'b1;
			end
			count <= count + CNT_WIDTH'(doWrite) - CNT_WIDTH'(doRead);
		end
	end

	// Read data register
	always_ff @(posedge inClock) begin
		if (doRead) begin
			o_rxData <= store[rdPtr];
		end
	end

	assign o_level = 4'(count);

endmodule

`default_nettype wire

// ==== design/modemTop.sv ====
`default_nettype none
`timescale 1ns/10ps

module modemTop #(
	parameter int FIFO_DEPTH = 8,
	parameter int SAMPLE_DIV = 4,
	parameter int ITERATIONS = 7
) (
	input  wire                    inClock,
	input  wire                    i_arstN,
	input  wire                    i_txWrite,
	input  wire modemPkg::nibbleT  i_txData,
	input  wire                    i_rxRead,
	input  var modemPkg::probeSelT i_probeSel,
	output logic                   o_writeError,
	output logic                   o_rxValid,
	output modemPkg::nibbleT       o_rxData,
	output logic                   o_readError,
	output logic [7:0]             o_probe
);
	import modemPkg::*;

	logic       txBit;
	logic       txBitEmpty;
	logic       txBitTaken;
	logic [3:0] txLevel;
	logic       sampleValid;
	logic       symbolLast;
	sampleT     sampleI;
	sampleT     sampleQ;
	logic       chainValid [ITERATIONS+1];
	logic       chainLast  [ITERATIONS+1];
	stageT      chainI     [ITERATIONS+1];
	stageT      chainQ     [ITERATIONS+1];
	angleT      chainAngle [ITERATIONS+1];
	logic       sliceStrobe;
	logic       sliceBit;
	angleT      sliceAngle;
	logic [3:0] rxLevel;
	logic       rxOverflow;
	logic       rxOverflowCount;

	////////////////////////////////////////////////////////////
	// Transmit side
	////////////////////////////////////////////////////////////
	txFifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_txFifo (
		.inClock      (inClock),
		.i_arstN      (i_arstN),
		.i_txWrite    (i_txWrite),
		.i_txData     (i_txData),
		.i_bitTaken   (txBitTaken),
		.o_bit        (txBit),
		.o_bitEmpty   (txBitEmpty),
		.o_writeError (o_writeError),
		.o_level      (txLevel)
	);

	mskModulator #(.SAMPLE_DIV(SAMPLE_DIV)) u_modulator (
		.inClock       (inClock),
		.i_arstN       (i_arstN),
		.i_bit         (txBit),
		.i_bitEmpty    (txBitEmpty),
		.o_bitTaken    (txBitTaken),
		.o_sampleValid (sampleValid),
		.o_sampleI     (sampleI),
		.o_sampleQ     (sampleQ),
		.o_symbolLast  (symbolLast)
	);

	////////////////////////////////////////////////////////////
	// CORDIC phase detector
	////////////////////////////////////////////////////////////
	cordicPrep u_cordicPrep (
		.inClock   (inClock),
		.i_arstN   (i_arstN),
		.i_valid   (sampleValid),
		.i_last    (symbolLast),
		.i_sampleI (sampleI),
		.i_sampleQ (sampleQ),
		.o_valid   (chainValid[0]),
		.o_last    (chainLast[0]),
		.o_I       (chainI[0]),
		.o_Q       (chainQ[0]),
		.o_angle   (chainAngle[0])
	);

	for (genvar k = 0; k < ITERATIONS; k++) begin : g_stage
		cordicStage #(.STAGE(k)) u_stage (
			.inClock (inClock),
			.i_arstN (i_arstN),
			.i_valid (chainValid[k]),
			.i_last  (chainLast[k]),
			.i_I     (chainI[k]),
			.i_Q     (chainQ[k]),
			.i_angle (chainAngle[k]),
			.o_valid (chainValid[k+1]),
			.o_last  (chainLast[k+1]),
			.o_I     (chainI[k+1]),
			.o_Q     (chainQ[k+1]),
			.o_angle (chainAngle[k+1])
		);
	end

	////////////////////////////////////////////////////////////
	// Receive side
	////////////////////////////////////////////////////////////
	bitSlicer u_bitSlicer (
		.inClock     (inClock),
		.i_arstN     (i_arstN),
		.i_valid     (chainValid[ITERATIONS]),
		.i_last      (chainLast[ITERATIONS]),
		.i_angle     (chainAngle[ITERATIONS]),
		.o_bitStrobe (sliceStrobe),
		.o_bit       (sliceBit),
		.o_angle     (sliceAngle)
	);

	rxFifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_rxFifo (
		.inClock     (inClock),
		.i_arstN     (i_arstN),
		.i_bitStrobe (sliceStrobe),
		.i_bit       (sliceBit),
		.i_rxRead    (i_rxRead),
		.o_rxValid   (o_rxValid),
		.o_rxData    (o_rxData),
		.o_readError (o_readError),
		.o_overflow  (rxOverflow),
		.o_level     (rxLevel)
	);

	// Each dropped rx nibble flips bit 7 of the rx level probe
	always_ff @(posedge inClock or negedge i_arstN) begin
		if (!i_arstN) begin
			rxOverflowCount <= 1'b0;
		end else if (rxOverflow) begin
			rxOverflowCount <= !rxOverflowCount;
		end
	end

	// Observation mux
	always_comb begin
		case (i_probeSel)
			PROBE_TX_LEVEL: o_probe = {4'b0, txLevel};
			PROBE_RX_LEVEL: o_probe = {rxOverflowCount, 3'b0, rxLevel};
			PROBE_ANGLE:    o_probe = sliceAngle[ANGLE_WIDTH-1 -: 8];
			default:        o_probe = '0;
		endcase
	end

endmodule

`default_nettype wire

// ==== tb/modemTop_sva.sv ====
`default_nettype none
`timescale 1ns/10ps

module modemTop_sva (
	input wire inClock,
	input wire i_arstN,
	input wire i_txWrite,
	input wire i_rxRead,
	input wire o_writeError,
	input wire o_rxValid,
	input wire o_readError
);

	// Read port answers with data or an error, never both
	rxExclusive: assert property (@(posedge inClock) disable iff (!i_arstN)
		!(o_rxValid && o_readError))
		else $error("o_rxValid and o_readError high in the same cycle");

	rxValidAfterRead: assert property (@(posedge inClock) disable iff (!i_arstN)
		o_rxValid |-> $past(i_rxRead))
		else $error("o_rxValid without a read one cycle before");

	// Dropped writes are flagged one cycle late
	writeErrorAfterWrite: assert property (@(posedge inClock) disable iff (!i_arstN)
		o_writeError |-> $past(i_txWrite))
		else $error("o_writeError without a write one cycle before");

endmodule

bind modemTop modemTop_sva u_sva (.*);

`default_nettype wire

// ==== tb/modemTop_tb.sv ====
`default_nettype none
`timescale 1ns/10ps

module modemTop_tb;
	import modemPkg::*;

	localparam int FIFO_DEPTH    = 8;
	localparam int SAMPLE_DIV    = 4;
	localparam int ITERATIONS    = 7;
	localparam int CLK_PERIOD    = 10;
	localparam int NIBBLE_CYCLES = 4 * SYMBOL_SAMPLES * SAMPLE_DIV;
	localparam int WAIT_LIMIT    = 2 * NIBBLE_CYCLES;
	// Roughly the summed length of all tests below
	localparam int TEST_CYCLES   = 2000;
	localparam int WATCHDOG_NS   = 3 * TEST_CYCLES * CLK_PERIOD;
	localparam int unsigned SEED = 32'ha27e_2385;

	logic       clock;
	logic       arstN;
	logic       txWrite;
	nibbleT     txData;
	logic       rxRead;
	probeSelT   probeSel;
	logic       writeError;
	logic       rxValid;
	nibbleT     rxData;
	logic       readError;
	logic [7:0] probe;
	int         errorCount = 0;
	int         checkCount = 0;

	modemTop #(
		.FIFO_DEPTH (FIFO_DEPTH),
		.SAMPLE_DIV (SAMPLE_DIV),
		.ITERATIONS (ITERATIONS)
	) UUT (
		.inClock      (clock),
		.i_arstN      (arstN),
		.i_txWrite    (txWrite),
		.i_txData     (txData),
		.i_rxRead     (rxRead),
		.i_probeSel   (probeSel),
		.o_writeError (writeError),
		.o_rxValid    (rxValid),
		.o_rxData     (rxData),
		.o_readError  (readError),
		.o_probe      (probe)
	);

	initial begin
		clock = 1'b0;
		forever #(CLK_PERIOD / 2) clock = ~clock;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("ERROR: run timed out after %0d ns, a test is stuck waiting on the DUT",
			WATCHDOG_NS);
		$display("TEST RESULT: FAIL");
		$finish;
	end

	////////////////////////////////////////////////////////////
	// Compare tasks
	////////////////////////////////////////////////////////////
	task automatic compareFlag(input logic expected, input logic actual, input string what);
		checkCount++;
		if (actual !== expected) begin
			errorCount++;
			$display("FAILED at %0t: %s, expected %0b, got %0b", $time, what, expected, actual);
		end
	endtask

	task automatic compareNibble(input nibbleT expected, input nibbleT actual,
		input string what);
		checkCount++;
		if (actual !== expected) begin
			errorCount++;
			$display("FAILED at %0t: %s, expected %h, got %h", $time, what, expected, actual);
		end
	endtask

	task automatic compareLevel(input logic [3:0] expected, input logic [3:0] actual,
		input string what);
		checkCount++;
		if (actual !== expected) begin
			errorCount++;
			$display("FAILED at %0t: %s, expected %0d, got %0d", $time, what, expected, actual);
		end
	endtask

	// Angle probe within a tolerance, in probe units
	task automatic compareAngle(input logic [7:0] expected, input logic [7:0] actual,
		input int tolerance, input string what);
		int diff;
		checkCount++;
		diff = int'(actual) - int'(expected);
		if ($isunknown(actual) || diff > tolerance || diff < -tolerance) begin
			errorCount++;
			$display("FAILED at %0t: %s, expected %0d +/- %0d, got %0d", $time, what,
				expected, tolerance, actual);
		end
	endtask

	////////////////////////////////////////////////////////////
	// Bus helpers
	////////////////////////////////////////////////////////////
	task automatic applyReset();
		@(posedge clock);
		arstN   <= 1'b0;
		txWrite <= 1'b0;
		rxRead  <= 1'b0;
		repeat (2) @(posedge clock);
		arstN <= 1'b1;
	endtask

	task automatic writeNibble(input nibbleT value, output logic rejected);
		@(posedge clock);
		txWrite <= 1'b1;
		txData  <= value;
		@(posedge clock);
		txWrite <= 1'b0;
		@(negedge clock);
		rejected = writeError;
	endtask

	task automatic readNibble(output nibbleT data, output logic valid, output logic error);
		@(posedge clock);
		rxRead <= 1'b1;
		@(posedge clock);
		rxRead <= 1'b0;
		@(negedge clock);
		data  = rxData;
		valid = rxValid;
		error = readError;
	endtask

	task automatic readAndCompare(input nibbleT expected, input string what);
		nibbleT data;
		logic   valid;
		logic   error;
		readNibble(data, valid, error);
		compareFlag(1'b1, valid, {what, ": o_rxValid"});
		compareFlag(1'b0, error, {what, ": o_readError"});
		compareNibble(expected, data, {what, ": o_rxData"});
	endtask

	task automatic probeRead(input probeSelT sel, output logic [7:0] value);
		@(posedge clock);
		probeSel <= sel;
		@(negedge clock);
		value = probe;
	endtask

	// Poll the rx level probe until it reaches the target
	task automatic waitRxLevel(input int target, input int limit);
		int   waited;
		logic reached;
		waited  = 0;
		reached = 1'b0;
		@(posedge clock);
		probeSel <= PROBE_RX_LEVEL;
		@(negedge clock);
		while (!reached && waited < limit) begin
			if (int'(probe[3:0]) >= target) begin
				reached = 1'b1;
			end else begin
				@(negedge clock);
				waited++;
			end
		end
		if (!reached) begin
			errorCount++;
			$display("ERROR: receive FIFO level did not reach %0d within %0d cycles",
				target, limit);
		end
	endtask

	////////////////////////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////////////////////////
	task automatic testReset();
		logic [7:0] value;
		@(negedge clock);
		compareFlag(1'b0, rxValid, "reset: o_rxValid");
		compareFlag(1'b0, readError, "reset: o_readError");
		compareFlag(1'b0, writeError, "reset: o_writeError");
		probeRead(PROBE_TX_LEVEL, value);
		compareLevel(4'd0, value[3:0], "reset: tx level");
		probeRead(PROBE_RX_LEVEL, value);
		compareLevel(4'd0, value[3:0], "reset: rx level");
		compareLevel(4'd0, value[7:4], "reset: rx overflow bit clear");
	endtask

	task automatic testReadEmpty();
		nibbleT data;
		logic   valid;
		logic   error;
		readNibble(data, valid, error);
		compareFlag(1'b1, error, "empty read: o_readError");
		compareFlag(1'b0, valid, "empty read: o_rxValid");
		@(negedge clock);
		compareFlag(1'b0, readError, "empty read: error is one pulse");
	endtask

	task automatic testSingleNibble();
		nibbleT     value;
		logic       rejected;
		logic [7:0] level;
		value = nibbleT'($urandom());
		writeNibble(value, rejected);
		compareFlag(1'b0, rejected, "single: write accepted");
		waitRxLevel(1, WAIT_LIMIT);
		compareLevel(4'd1, probe[3:0], "single: rx level");
		readAndCompare(value, "single");
		probeRead(PROBE_TX_LEVEL, level);
		compareLevel(4'd0, level[3:0], "single: tx level drained");
	endtask

	task automatic testBurst();
		nibbleT     sent [$];
		nibbleT     value;
		logic       rejected;
		logic [7:0] level;
		for (int i = 0; i < FIFO_DEPTH; i++) begin
			value = nibbleT'($urandom());
			sent.push_back(value);
			writeNibble(value, rejected);
			compareFlag(1'b0, rejected, "burst: write accepted");
			repeat (NIBBLE_CYCLES - 2) @(posedge clock);
		end
		waitRxLevel(FIFO_DEPTH, WAIT_LIMIT);
		compareLevel(4'(FIFO_DEPTH), probe[3:0], "burst: rx level full");
		compareLevel(4'd0, probe[7:4], "burst: no rx nibble dropped");
		// A full rx FIFO must not leak through the idle probe
		probeRead(PROBE_OFF, level);
		compareLevel(4'd0, level[3:0], "burst: probe off");
		while (sent.size() > 0) begin
			readAndCompare(sent.pop_front(), "burst");
		end
	endtask

	task automatic testOverflow();
		nibbleT     written [$];
		logic       rejected [$];
		nibbleT     value;
		int         total;
		int         rejectCount;
		logic       seenReject;
		logic [7:0] level;
		total       = FIFO_DEPTH + 3;
		rejectCount = 0;
		seenReject  = 1'b0;
		// Back to back, the error for write i shows one cycle later
		for (int i = 0; i <= total; i++) begin
			@(posedge clock);
			if (i < total) begin
				value = nibbleT'($urandom());
				written.push_back(value);
				txWrite <= 1'b1;
				txData  <= value;
			end else begin
				txWrite <= 1'b0;
			end
			@(negedge clock);
			if (i > 0) begin
				rejected.push_back(writeError);
			end
		end
		// Store full and the shifter still busy with the first nibble
		probeRead(PROBE_TX_LEVEL, level);
		compareLevel(4'(FIFO_DEPTH + 1), level[3:0], "overflow: tx level full");
		for (int i = 0; i < total; i++) begin
			compareFlag(1'b0, seenReject && !rejected[i], "overflow: accepted after a reject");
			if (rejected[i]) begin
				seenReject = 1'b1;
				rejectCount++;
			end
		end
		compareFlag(1'b1, rejectCount > 0, "overflow: at least one write rejected");
		for (int i = 0; i < total; i++) begin
			if (!rejected[i]) begin
				waitRxLevel(1, WAIT_LIMIT);
				readAndCompare(written[i], "overflow");
			end
		end
	endtask

	task automatic testProbeAngle();
		logic rejected;
		int   waited;
		// Start from the reset phase so the angle is known
		applyReset();
		writeNibble(4'hF, rejected);
		compareFlag(1'b0, rejected, "angle: write accepted");
		@(posedge clock);
		probeSel <= PROBE_ANGLE;
		@(negedge clock);
		waited = 0;
		while (probe == 8'd0 && waited < WAIT_LIMIT) begin
			@(negedge clock);
			waited++;
		end
		if (probe == 8'd0) begin
			errorCount++;
			$display("ERROR: angle probe never moved from zero after the write");
		end else begin
			// Next sample, two sixteenths of a turn from reset
			repeat (SAMPLE_DIV) @(posedge clock);
			@(negedge clock);
			compareAngle(8'd32, probe, 4, "angle: second sample of first symbol");
		end
		waitRxLevel(1, WAIT_LIMIT);
		readAndCompare(4'hF, "angle nibble");
	endtask

	initial begin
		void'($urandom(SEED));
		arstN    = 1'b0;
		txWrite  = 1'b0;
		txData   = '0;
		rxRead   = 1'b0;
		probeSel = PROBE_OFF;
		repeat (2) @(posedge clock);
		arstN <= 1'b1;

		testReset();
		testReadEmpty();
		testSingleNibble();
		testBurst();
		testOverflow();
		testProbeAngle();

		$display("Checks run: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== modemTop.f ====
common/modemPkg.sv
design/txFifo.sv
design/mskModulator.sv
cordic/cordicPrep.sv
cordic/cordicStage.sv
design/bitSlicer.sv
design/rxFifo.sv
design/modemTop.sv
tb/modemTop_sva.sv
tb/modemTop_tb.sv

// ==== Bender.yml ====
package:
  name: modem_top

sources:
  - common/modemPkg.sv
  - design/txFifo.sv
  - design/mskModulator.sv
  - cordic/cordicPrep.sv
  - cordic/cordicStage.sv
  - design/bitSlicer.sv
  - design/rxFifo.sv
  - design/modemTop.sv
  - target: test
    files:
      - tb/modemTop_sva.sv
      - tb/modemTop_tb.sv
